//--- files.f
+incdir+rtl
+incdir+bench
rtl/rx_proc_pkg.sv
rtl/rx_hdr_capture.sv
rtl/rx_hdr_strip.sv
rtl/rx_ctrl_regs.sv
rtl/rx_data_proc.sv
bench/rx_proc_tb.sv

//--- Bender.yml
package:
  name: rx_data_proc

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rx_proc_pkg.sv
      - rtl/rx_hdr_capture.sv
      - rtl/rx_hdr_strip.sv
      - rtl/rx_ctrl_regs.sv
      - rtl/rx_data_proc.sv
  - target: test
    include_dirs:
      - rtl
      - bench
    files:
      - bench/rx_proc_tb.sv

//--- bench/rx_proc_tb_tests.svh
// packet builder, stream and APB drivers, directed tests for stripping, counting and registers
`ifndef RX_PROC_TB_TESTS_SVH
`define RX_PROC_TB_TESTS_SVH

function automatic logic [`RX_KEEP_W-1:0] keep_mask(input int nbytes);
    logic [`RX_KEEP_W:0] m;
    m = ({{`RX_KEEP_W{1'b0}}, 1'b1} << nbytes) - 1'b1;
    return m[`RX_KEEP_W-1:0];
endfunction

// fills pkt_beats and queues the stripped beats
// output byte j of beat k is stream byte 16k+j+8 or zero past the packet end
task automatic build_packet(input int nbeats, input logic [`RX_QPN_W-1:0] qpn,
                            input int last_bytes);
    rx_beat_t   b;
    rx_beat_t   e;
    logic [7:0] bytes [$];
    logic       valid [$];
    int         idx;
    pkt_beats.delete();
    for (int k = 0; k < nbeats; k++) begin
        b.data = {rand_word(), rand_word(), rand_word(), rand_word()};
        b.user = rand_word();
        b.last = (k == nbeats - 1);
        b.keep = b.last ? keep_mask(last_bytes) : '1;
        if (k == 0) begin
            b.data[`RX_QPN_LSB +: `RX_QPN_W] = qpn;
        end
        for (int i = 0; i < `RX_KEEP_W; i++) begin
            if (!b.keep[i]) begin
                b.data[i*8 +: 8] = 8'h00;
            end
            bytes.push_back(b.data[i*8 +: 8]);
            valid.push_back(b.keep[i]);
        end
        pkt_beats.push_back(b);
    end
    for (int k = 0; k < nbeats; k++) begin
        for (int j = 0; j < `RX_KEEP_W; j++) begin
            idx = k * `RX_KEEP_W + j + `RX_HDR_BYTES;
            e.data[j*8 +: 8] = (idx < bytes.size()) ? bytes[idx] : 8'h00;
            e.keep[j]        = (idx < valid.size()) ? valid[idx] : 1'b0;
        end
        e.last = (k == nbeats - 1);
        e.user = {qpn, pkt_beats[k].user[`RX_USER_W-`RX_QPN_W-1:0]};
        expect_q.push_back(e);
    end
endtask

task automatic send_packet();
    logic accepted;
    for (int k = 0; k < pkt_beats.size(); k++) begin
        s_beat   = pkt_beats[k];
        s_valid  = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = s_ready;
            @(posedge clk);
            #1;
        end
    end
    s_valid = 1'b0;
    pkts_sent++;
endtask

task automatic send_random_packet();
    int          nbeats;
    logic [31:0] qpn_word;
    int          last_bytes;
    nbeats     = 1 + rand_word() % 4;
    qpn_word   = rand_word();
    last_bytes = 9 + rand_word() % 8;
    build_packet(nbeats, qpn_word[`RX_QPN_W-1:0], last_bytes);
    send_packet();
endtask

// the counter settles two edges after the last accept
task automatic wait_drained();
    while (expect_q.size() != 0) begin
        @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #1;
endtask

task automatic apb_access(input logic write, input logic [`APB_ADDR_W-1:0] addr,
                          input logic [`APB_DATA_W-1:0] wdata,
                          output logic [`APB_DATA_W-1:0] rdata);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(negedge clk);
    assert (apb_rsp.pready == 1'b0) else report_error("pready high in the setup phase");
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk);
    check_value("apb_rsp.pready", apb_rsp.pready, 1'b1);
    check_value("apb_rsp.pslverr", apb_rsp.pslverr, 1'b0);
    rdata = apb_rsp.prdata;
    @(posedge clk);
    #1;
    apb_req = '0;
endtask

task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [`APB_DATA_W-1:0] unused;
    apb_access(1'b1, addr, data, unused);
endtask

task automatic read_check(input string name, input logic [`APB_ADDR_W-1:0] addr,
                          input logic [`APB_DATA_W-1:0] exp);
    logic [`APB_DATA_W-1:0] data;
    apb_access(1'b0, addr, '0, data);
    check_value(name, data, exp);
endtask

task automatic reset_values();
    @(negedge clk);
    check_value("m_valid", m_valid, 1'b0);
    check_value("s_ready", s_ready, 1'b1);
    @(posedge clk);
    #1;
    read_check("HDR_LO", HDR_LO, 32'h0);
    read_check("PKT_CNT", PKT_CNT, 32'h0);
    read_check("CLEAR", CLEAR, 32'h0);
endtask

task automatic strip_single_beat();
    int start_cnt;
    start_cnt = out_beat_cnt;
    build_packet(1, 24'hA1B2C3, 13);
    send_packet();
    wait_drained();
    check_value("single packet beat count", out_beat_cnt - start_cnt, 1);
endtask

task automatic strip_multi_beat();
    logic [31:0]          qpn_word;
    logic [`RX_QPN_W-1:0] qpn;
    qpn_word = rand_word();
    qpn      = qpn_word[`RX_QPN_W-1:0];
    build_packet(4, qpn, 9 + rand_word() % 8);
    send_packet();
    wait_drained();
    read_check("HDR_LO", HDR_LO, pkt_beats[0].data[31:0]);
    read_check("HDR_HI", HDR_HI, pkt_beats[0].data[63:32]);
    read_check("HDR_KEEP", HDR_KEEP, {16'h0, pkt_beats[0].keep});
    read_check("DEST_QPN", DEST_QPN, {8'h0, qpn});
endtask

task automatic stall_output();
    int start_cnt;
    int expect_cnt;
    start_cnt  = out_beat_cnt;
    expect_cnt = 0;
    bp_enable  = 1'b1;
    repeat (5) begin
        send_random_packet();
        expect_cnt += pkt_beats.size();
    end
    wait_drained();
    bp_enable = 1'b0;
    check_value("back-pressure beat count", out_beat_cnt - start_cnt, expect_cnt);
endtask

task automatic count_and_clear();
    read_check("PKT_CNT", PKT_CNT, pkts_sent);
    repeat (2) send_random_packet();
    wait_drained();
    read_check("PKT_CNT", PKT_CNT, pkts_sent);
    apb_write(CLEAR, 32'h1);
    read_check("PKT_CNT", PKT_CNT, 32'h0);
    read_check("CLEAR", CLEAR, 32'h1);
    repeat (2) send_random_packet();
    wait_drained();
    read_check("PKT_CNT", PKT_CNT, 32'h0);
    apb_write(CLEAR, 32'h0);
    repeat (3) send_random_packet();
    wait_drained();
    read_check("PKT_CNT", PKT_CNT, 32'd3);
endtask

task automatic register_map_reads();
    read_check("VERSION", VERSION, `RX_VERSION);
    read_check("unmapped 0x1C", 8'h1C, 32'h0);
    read_check("unmapped 0x40", 8'h40, 32'h0);
endtask

`endif

//--- bench/rx_proc_tb.sv
// testbench top with clock, reset, DUT, xorshift source, stream driver, monitor and timeout
`default_nettype none
`include "rx_proc_settings.svh"

module rx_proc_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rx_proc_pkg::*;

    // about 15 packets of up to 4 beats, slowed by back-pressure, plus some 20 APB
    // accesses of 2 cycles each stay well below 400 cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic     clk;
    logic     rst;
    rx_beat_t s_beat;
    logic     s_valid;
    logic     s_ready;
    rx_beat_t m_beat;
    logic     m_valid;
    logic     m_ready;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    logic [31:0] rng_state = 32'h5dd7;
    logic        bp_enable;
    int          cycle_cnt = 0;
    int          out_beat_cnt = 0;
    int          pkts_sent = 0;
    rx_beat_t    pkt_beats [$];
    rx_beat_t    expect_q [$];

    rx_data_proc u_dut (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        stop_run();
    endtask

    task automatic report_mismatch(input string name, input logic [191:0] got,
                                   input logic [191:0] exp);
        $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [191:0] got,
                               input logic [191:0] exp);
        assert (got == exp) else report_mismatch(name, got, exp);
    endtask

    `include "rx_proc_tb_tests.svh"

    // m_ready draws its next value at the falling edge and drives it after the rising edge
    initial begin : ready_sink
        logic [31:0] r;
        logic        next_ready;
        m_ready    = 1'b1;
        next_ready = 1'b1;
        forever begin
            @(negedge clk);
            r = bp_enable ? rand_word() : 32'h1;
            next_ready = r[0];
            @(posedge clk);
            #1;
            m_ready = next_ready;
        end
    end

    // scoreboard compare on every output transfer
    always @(negedge clk) begin : output_monitor
        rx_beat_t exp_beat;
        if (!rst && m_valid && m_ready) begin
            assert (expect_q.size() != 0) else report_error("output beat with none expected");
            exp_beat = expect_q.pop_front();
            check_value("m_beat.data", m_beat.data, exp_beat.data);
            check_value("m_beat.keep", m_beat.keep, exp_beat.keep);
            check_value("m_beat.last", m_beat.last, exp_beat.last);
            check_value("m_beat.user", m_beat.user, exp_beat.user);
            out_beat_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        assert (cycle_cnt < TIMEOUT_CYCLES) else report_error("run exceeded the cycle limit");
    end

    initial begin
        rst       = 1'b1;
        s_valid   = 1'b0;
        s_beat    = '0;
        apb_req   = '0;
        bp_enable = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_values();
        strip_single_beat();
        strip_multi_beat();
        stall_output();
        count_and_clear();
        register_map_reads();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/rx_data_proc.sv
// receive data processing top with header capture, header stripper and register bank
`default_nettype none
`include "rx_proc_settings.svh"

module rx_data_proc (
    input  wire                        clk,
    input  wire                        rst,
    input  wire rx_proc_pkg::rx_beat_t s_beat,
    input  wire                        s_valid,
    output logic                       s_ready,
    output rx_proc_pkg::rx_beat_t      m_beat,
    output logic                       m_valid,
    input  wire                        m_ready,
    input  wire rx_proc_pkg::apb_req_t apb_req,
    output rx_proc_pkg::apb_rsp_t      apb_rsp
);

    logic                       accept;
    logic [`RX_HDR_BYTES*8-1:0] hdr;
    logic [`RX_KEEP_W-1:0]      hdr_keep;
    logic [`RX_QPN_W-1:0]       dest_qpn;
    logic                       pkt_end;

    // capture taps the input side of the stripper
    assign accept = s_valid && s_ready;

    rx_hdr_capture u_capture (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .beat     (s_beat),
        .hdr      (hdr),
        .hdr_keep (hdr_keep),
        .dest_qpn (dest_qpn),
        .pkt_end  (pkt_end)
    );

    rx_hdr_strip u_strip (
        .clk      (clk),
        .rst      (rst),
        .s_beat   (s_beat),
        .s_valid  (s_valid),
        .s_ready  (s_ready),
        .dest_qpn (dest_qpn),
        .m_beat   (m_beat),
        .m_valid  (m_valid),
        .m_ready  (m_ready)
    );

    rx_ctrl_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .hdr      (hdr),
        .hdr_keep (hdr_keep),
        .dest_qpn (dest_qpn),
        .pkt_end  (pkt_end)
    );

endmodule

`default_nettype wire

//--- rtl/rx_ctrl_regs.sv
// APB register bank with header view, packet counter, version word and clear flag
`default_nettype none
`include "rx_proc_settings.svh"

module rx_ctrl_regs (
    input  wire                        clk,
    input  wire                        rst,
    input  wire rx_proc_pkg::apb_req_t apb_req,
    output rx_proc_pkg::apb_rsp_t      apb_rsp,
    input  wire [`RX_HDR_BYTES*8-1:0]  hdr,
    input  wire [`RX_KEEP_W-1:0]       hdr_keep,
    input  wire [`RX_QPN_W-1:0]        dest_qpn,
    input  wire                        pkt_end
);

    import rx_proc_pkg::*;

    localparam int DW = `APB_DATA_W;

    reg_addr_e         addr;
    logic              access;
    logic              wr_clear;
    logic              clear_flag;
    logic [DW-1:0]     pkt_cnt;
    logic [DW-1:0]     rd_data;

    assign addr     = reg_addr_e'(apb_req.paddr);
    // zero wait states, every access phase completes
    assign access   = apb_req.psel && apb_req.penable;
    assign wr_clear = access && apb_req.pwrite && (addr == CLEAR);

    always_ff @(posedge clk) begin
        if (rst) begin
            clear_flag <= 1'b0;
        end else if (wr_clear) begin
            clear_flag <= apb_req.pwdata[0];
        end
    end

    // counter sits at zero for as long as the clear flag is set
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_cnt <= '0;
        end else if (clear_flag) begin
            pkt_cnt <= '0;
        end else if (pkt_end) begin
            pkt_cnt <= pkt_cnt + 1'b1;
        end
    end

    // read mux, unmapped offsets give zero
    always_comb begin
        rd_data = '0;
        case (addr)
            HDR_LO: begin
                rd_data = hdr[DW-1:0];
            end
            HDR_HI: begin
                rd_data = hdr[2*DW-1:DW];
            end
            HDR_KEEP: begin
                rd_data = {{(DW-`RX_KEEP_W){1'b0}}, hdr_keep};
            end
            DEST_QPN: begin
                rd_data = {{(DW-`RX_QPN_W){1'b0}}, dest_qpn};
            end
            PKT_CNT: begin
                rd_data = pkt_cnt;
            end
            VERSION: begin
                rd_data = `RX_VERSION;
            end
            CLEAR: begin
                rd_data = {{(DW-1){1'b0}}, clear_flag};
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    always_comb begin
        apb_rsp.pready  = access;
        apb_rsp.pslverr = 1'b0;
        apb_rsp.prdata  = '0;
        if (access && !apb_req.pwrite) begin
            apb_rsp.prdata = rd_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rx_hdr_strip.sv
// header stripper with beat realignment, back-pressure hold stage and QPN tagging of tuser
`default_nettype none
`include "rx_proc_settings.svh"

module rx_hdr_strip (
    input  wire                        clk,
    input  wire                        rst,
    input  wire rx_proc_pkg::rx_beat_t s_beat,
    input  wire                        s_valid,
    output logic                       s_ready,
    input  wire [`RX_QPN_W-1:0]        dest_qpn,
    output rx_proc_pkg::rx_beat_t      m_beat,
    output logic                       m_valid,
    input  wire                        m_ready
);

    import rx_proc_pkg::*;

    localparam int HDR_BITS  = `RX_HDR_BYTES * 8;
    localparam int USER_LO_W = `RX_USER_W - `RX_QPN_W;

    strip_state_e state;
    strip_state_e state_next;
    rx_beat_t     held;
    rx_beat_t     out_q;
    rx_beat_t     out_next;
    logic         out_free;
    logic         accept;
    logic         load_out;
    logic         load_held;

    // upper part of lo followed by the header-sized front of hi
    function automatic rx_beat_t join_beat(input rx_beat_t lo, input rx_beat_t hi,
                                           input logic last);
        rx_beat_t b;
        b.data = {hi.data[HDR_BITS-1:0], lo.data[`RX_DATA_W-1:HDR_BITS]};
        b.keep = {hi.keep[`RX_HDR_BYTES-1:0], lo.keep[`RX_KEEP_W-1:`RX_HDR_BYTES]};
        b.last = last;
        b.user = lo.user;
        return b;
    endfunction

    assign out_free = !m_valid || m_ready;
    // a held last beat waits for its tail to be emitted
    assign s_ready  = out_free && (state == EMPTY || (state == HOLD && !held.last));
    assign accept   = s_valid && s_ready;

    always_comb begin
        state_next = state;
        load_out   = 1'b0;
        load_held  = 1'b0;
        out_next   = join_beat(held, s_beat, 1'b0);
        case (state)
            EMPTY: begin
                if (accept) begin
                    load_held = 1'b1;
                    if (s_beat.last) begin
                        // single-beat packet goes straight to the tail
                        load_out   = 1'b1;
                        out_next   = join_beat(s_beat, '0, 1'b1);
                        state_next = TAIL;
                    end else begin
                        state_next = HOLD;
                    end
                end
            end
            HOLD: begin
                if (held.last) begin
                    if (out_free) begin
                        load_out   = 1'b1;
                        out_next   = join_beat(held, '0, 1'b1);
                        state_next = TAIL;
                    end
                end else if (accept) begin
                    load_out  = 1'b1;
                    load_held = 1'b1;
                end
            end
            TAIL: begin
                if (m_ready) begin
                    state_next = EMPTY;
                end
            end
            default: state_next = EMPTY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= EMPTY;
            m_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (load_out) begin
                m_valid <= 1'b1;
            end else if (m_ready) begin
                m_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_held) begin
            held <= s_beat;
        end
        if (load_out) begin
            out_q <= out_next;
        end
    end

    // QPN stays stable until the tail has left, so it is merged at the output
    always_comb begin
        m_beat      = out_q;
        m_beat.user = {dest_qpn, out_q.user[USER_LO_W-1:0]};
    end

endmodule

`default_nettype wire

//--- rtl/rx_hdr_capture.sv
// first-beat tracking with header, keep and destination QPN capture and packet-end strobe
`default_nettype none
`include "rx_proc_settings.svh"

module rx_hdr_capture (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        accept,
    input  wire rx_proc_pkg::rx_beat_t beat,
    output logic [`RX_HDR_BYTES*8-1:0] hdr,
    output logic [`RX_KEEP_W-1:0]      hdr_keep,
    output logic [`RX_QPN_W-1:0]       dest_qpn,
    output logic                       pkt_end
);

    localparam int HDR_BITS = `RX_HDR_BYTES * 8;

    // beats seen so far in the current packet, sticks at all ones
    logic [7:0] beat_cnt;
    logic       first_beat;

    assign first_beat = (beat_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (accept) begin
            if (beat.last) begin
                beat_cnt <= '0;
            end else if (beat_cnt != '1) begin
                beat_cnt <= beat_cnt + 8'd1;
            end
        end
    end

    // header view, only the first beat of a packet carries it
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr      <= '0;
            hdr_keep <= '0;
            dest_qpn <= '0;
        end else if (accept && first_beat) begin
            hdr      <= beat.data[HDR_BITS-1:0];
            hdr_keep <= beat.keep;
            dest_qpn <= beat.data[`RX_QPN_LSB +: `RX_QPN_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_end <= 1'b0;
        end else begin
            pkt_end <= accept && beat.last;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rx_proc_pkg.sv
// stream beat and APB structs, register map and stripper state enums
`default_nettype none
`include "rx_proc_settings.svh"

package rx_proc_pkg;

    // one stream beat, byte 0 in data[7:0]
    typedef struct packed {
        logic [`RX_DATA_W-1:0] data;
        logic [`RX_KEEP_W-1:0] keep;
        logic                  last;
        logic [`RX_USER_W-1:0] user;
    } rx_beat_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                   pready;
        logic                   pslverr;
        logic [`APB_DATA_W-1:0] prdata;
    } apb_rsp_t;

    // register offsets, byte addressed
    typedef enum logic [`APB_ADDR_W-1:0] {
        HDR_LO   = 8'h00,
        HDR_HI   = 8'h04,
        HDR_KEEP = 8'h08,
        DEST_QPN = 8'h0C,
        PKT_CNT  = 8'h10,
        VERSION  = 8'h14,
        CLEAR    = 8'h18
    } reg_addr_e;

    typedef enum logic [1:0] {
        EMPTY,
        HOLD,
        TAIL
    } strip_state_e;

endpackage

`default_nettype wire

//--- rtl/rx_proc_settings.svh
// stream widths, header geometry, QPN field position, version word and APB widths
`ifndef RX_PROC_SETTINGS_SVH
`define RX_PROC_SETTINGS_SVH

// stream beat
`define RX_DATA_W     128
`define RX_KEEP_W     16
`define RX_USER_W     32

// header carried at the front of every packet
`define RX_HDR_BYTES  8
// destination QPN field inside the header, bits 32..55
`define RX_QPN_LSB    32
`define RX_QPN_W      24

`define RX_VERSION    32'h20231219

// register bus
`define APB_ADDR_W    8
`define APB_DATA_W    32

`endif
